// ==== dma_copy_top.f ====
design/dma_pkg.sv
design/stream_fifo.sv
design/copy_sequencer.sv
design/simple_dma.sv
design/dma_copy_top.sv
verification/dma_copy_properties.sv
verification/dma_copy_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the copy engine testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module dma_copy_tb -f dma_copy_top.f -o dma_copy_sim

output=$(./obj_dir/dma_copy_sim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// ==== verification/dma_copy_tb.sv ====
`timescale 1ns/1ps

module dma_copy_tb
    import dma_pkg::*;
();

    localparam addr_t       src_base     = 32'h0001_0000;
    localparam addr_t       dst_base     = 32'h0008_0000;
    localparam int unsigned region_words = 1024;
    localparam int unsigned wait_limit   = 40000;   // cycles, enough for 700 words under stalls.

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      cmd_valid = 1'b0;
    logic      cmd_ready;
    copy_cmd_t cmd = '0;
    logic      done;
    logic      ar_valid, r_ready, aw_valid, w_valid, b_ready;
    logic      ar_ready = 1'b0;
    logic      r_valid = 1'b0;
    logic      aw_ready = 1'b0;
    logic      w_ready = 1'b0;
    logic      b_valid = 1'b0;
    axi_ar_t   ar, aw;
    axi_r_t    r = '0;
    axi_w_t    w;
    resp_t     b_resp = '0;

    data_t       mem [addr_t];
    data_t       ref_mem [addr_t];   // expected memory contents.
    axi_ar_t     rd_bursts [$];
    axi_ar_t     wr_bursts [$];
    axi_ar_t     ar_log [$];
    axi_ar_t     aw_log [$];
    int unsigned rd_beat, wr_beat, b_owed;
    int unsigned stall_pct = 0;
    int unsigned checks, errors, timeouts, accepted, done_count;

    dma_copy_top #(.COUNT_WIDTH(16), .FIFO_DEPTH(16)) UUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (!rst && done) begin
            done_count <= done_count + 1;
        end
    end

    function automatic bit random_ready();
        return ($urandom % 100) >= stall_pct;
    endfunction

    function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
        return lo + ($urandom % (hi - lo + 1));
    endfunction

    // unwritten words read back as a pattern unique to their address.
    function automatic data_t fill_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic data_t read_mem(input addr_t a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic data_t read_ref(input addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    // ==============================
    // AXI slave memory
    // ==============================

    always @(posedge clk) begin : read_slave
        addr_t a;
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            rd_beat = 0;
        end else begin
            if (ar_valid && ar_ready) begin
                rd_bursts.push_back(ar);
                ar_log.push_back(ar);
            end
            if (r_valid && r_ready) begin
                if (r.last) begin
                    void'(rd_bursts.pop_front());
                    rd_beat = 0;
                end else begin
                    rd_beat++;
                end
            end
            if (!r_valid || r_ready) begin   // a stalled beat keeps its payload.
                if (rd_bursts.size() != 0 && random_ready()) begin
                    a = rd_bursts[0].addr + (addr_t'(rd_beat) << word_bytes_log2);
                    r_valid <= 1'b1;
                    r <= '{data: read_mem(a), resp: 2'b00,
                           last: rd_beat == 32'(rd_bursts[0].len)};
                end else begin
                    r_valid <= 1'b0;
                end
            end
            ar_ready <= random_ready();
        end
    end

    always @(posedge clk) begin : write_slave
        addr_t a;
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                wr_bursts.push_back(aw);
                aw_log.push_back(aw);
            end
            if (w_valid && w_ready) begin
                if (wr_bursts.size() == 0) begin
                    errors++;
                    $display("a write data beat arrived with no open write burst");
                end else begin
                    a = wr_bursts[0].addr + (addr_t'(wr_beat) << word_bytes_log2);
                    mem[a] = w.data;
                    if (w.last) begin
                        void'(wr_bursts.pop_front());
                        wr_beat = 0;
                        b_owed++;
                    end else begin
                        wr_beat++;
                    end
                end
            end
            if (b_valid && b_ready) begin
                b_owed--;
            end
            if (!b_valid || b_ready) begin
                b_valid <= b_owed != 0 && random_ready();
            end
            aw_ready <= random_ready();
            w_ready  <= random_ready();
        end
    end

    // ==============================
    // checks
    // ==============================

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input burst_len_t got, input burst_len_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_memory();
        check_count("memory word count", mem.num(), ref_mem.num());
        foreach (mem[a]) begin
            check_word($sformatf("mem[%h]", a), mem[a], read_ref(a));
        end
    endtask

    // walks the burst split for a transfer and compares it with the logged requests.
    task automatic check_bursts(input string name, input axi_ar_t log [$], input addr_t start,
                                input int unsigned count);
        addr_t       addr;
        int unsigned left;
        int unsigned beats;
        int unsigned i;
        addr = start;
        left = count;
        i = 0;
        while (left != 0) begin
            beats = left < max_burst ? left : max_burst;
            if (i < log.size()) begin
                check_addr($sformatf("%s[%0d].addr", name, i), log[i].addr, addr);
                check_len($sformatf("%s[%0d].len", name, i), log[i].len, burst_len_t'(beats - 1));
            end
            addr = addr + (addr_t'(beats) << word_bytes_log2);
            left = left - beats;
            i++;
        end
        check_count({name, " burst count"}, log.size(), i);
    endtask

    task automatic send_cmd(input addr_t src, input addr_t dst, input int unsigned count);
        copy_cmd_t   c;
        addr_t       off;
        int unsigned i;
        int unsigned n;
        c = '{src: src, dst: dst, count: 16'(count)};
        for (i = 0; i < count; i++) begin
            off = addr_t'(i) << word_bytes_log2;
            ref_mem[dst + off] = read_ref(src + off);
        end
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cmd_ready && n < wait_limit);
        cmd_valid <= 1'b0;
        if (cmd_ready) begin
            accepted++;
        end else begin
            timeouts++;
            $display("timed out waiting for the command to be accepted");
        end
    endtask

    task automatic wait_done();
        int unsigned n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!done && n < wait_limit);
        if (!done) begin
            timeouts++;
            $display("timed out waiting for done");
        end
    endtask

    task automatic run_copy(input int unsigned count, output addr_t src, output addr_t dst);
        src = src_base + (addr_t'($urandom % (region_words - count + 1)) << word_bytes_log2);
        dst = dst_base + (addr_t'($urandom % (region_words - count + 1)) << word_bytes_log2);
        send_cmd(src, dst, count);
        wait_done();
        repeat (2) @(negedge clk);
        check_count("done pulses", done_count, accepted);
        check_memory();
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        int unsigned n;
        int unsigned i;
        addr_t       src, dst;
        data_t       v;
        void'($urandom(32'h86fa));
        for (i = 0; i < region_words; i++) begin
            v = $urandom;
            mem[src_base + (addr_t'(i) << word_bytes_log2)] = v;
            ref_mem[src_base + (addr_t'(i) << word_bytes_log2)] = v;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        check_bit("cmd_ready", cmd_ready, 1'b1);
        check_bit("ar_valid", ar_valid, 1'b0);
        check_bit("aw_valid", aw_valid, 1'b0);
        check_bit("w_valid", w_valid, 1'b0);
        check_bit("r_ready", r_ready, 1'b0);
        check_bit("b_ready", b_ready, 1'b0);
        check_bit("done", done, 1'b0);

        run_copy(rand_range(1, 20), src, dst);

        ar_log.delete();
        aw_log.delete();
        n = rand_range(300, 700);
        run_copy(n, src, dst);
        check_bursts("ar", ar_log, src, n);
        check_bursts("aw", aw_log, dst, n);

        // a zero count must finish without any bus request.
        ar_log.delete();
        aw_log.delete();
        run_copy(0, src, dst);
        check_bursts("ar", ar_log, src, 0);
        check_bursts("aw", aw_log, dst, 0);

        stall_pct = 30;
        repeat (20) begin
            run_copy(rand_range(0, 64), src, dst);
        end

        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verification/dma_copy_properties.sv ====
`timescale 1ns/1ps

module dma_copy_properties
    import dma_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    ar_valid,
    input logic    ar_ready,
    input axi_ar_t ar,
    input logic    aw_valid,
    input logic    aw_ready,
    input axi_ar_t aw,
    input logic    w_valid,
    input logic    w_ready,
    input axi_w_t  w,
    input logic    done
);

    burst_len_t cur_len;    // len of the open write burst.
    logic [8:0] beat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_len  <= '0;
            beat_cnt <= '0;
        end else begin
            if (aw_valid && aw_ready) begin
                cur_len <= aw.len;
            end
            if (w_valid && w_ready) begin
                beat_cnt <= w.last ? 9'd0 : beat_cnt + 9'd1;
            end
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("AR payload changed or valid dropped while stalled");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW payload changed or valid dropped while stalled");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("W payload changed or valid dropped while stalled");

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // a new write burst opens only after the previous one has sent all its beats.
    w_beats: assert property (@(posedge clk) disable iff (rst)
        aw_valid && aw_ready |-> beat_cnt == 9'd0)
        else $error("write burst opened before the previous burst had all its beats");

    w_last: assert property (@(posedge clk) disable iff (rst)
        w_valid && w_ready |-> w.last == (beat_cnt == {1'b0, cur_len}))
        else $error("w.last did not mark the final beat of the burst");

endmodule

bind dma_copy_top dma_copy_properties u_properties (.*);

// ==== design/dma_copy_top.sv ====
`timescale 1ns/1ps

module dma_copy_top
    import dma_pkg::*;
#(
    parameter int COUNT_WIDTH = 16,   // at most the 16 bits of the command count.
    parameter int FIFO_DEPTH  = 16
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  copy_cmd_t cmd,
    output logic      done,

    output logic      ar_valid,
    input  logic      ar_ready,
    output axi_ar_t   ar,
    input  logic      r_valid,
    output logic      r_ready,
    input  axi_r_t    r,
    output logic      aw_valid,
    input  logic      aw_ready,
    output axi_ar_t   aw,
    output logic      w_valid,
    input  logic      w_ready,
    output axi_w_t    w,
    input  logic      b_valid,
    output logic      b_ready,
    input  resp_t     b_resp
);

    // ==============================
    // internal channels
    // ==============================

    logic                   read_addr_valid, read_addr_ready;
    addr_t                  read_addr;
    logic                   read_count_valid, read_count_ready;
    logic [COUNT_WIDTH-1:0] read_count;
    logic                   write_addr_valid, write_addr_ready;
    addr_t                  write_addr;
    logic                   write_count_valid, write_count_ready;
    logic [COUNT_WIDTH-1:0] write_count;

    logic                   read_data_valid, read_data_ready;
    data_t                  read_data;
    logic                   write_data_valid, write_data_ready;
    data_t                  write_data;
    logic                   r_idle, w_idle;

    copy_sequencer #(.COUNT_WIDTH(COUNT_WIDTH)) u_sequencer (.*);

    simple_dma #(.COUNT_WIDTH(COUNT_WIDTH)) u_dma (.*);

    stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (read_data_valid),
        .in_ready  (read_data_ready),
        .in_data   (read_data),
        .out_valid (write_data_valid),
        .out_ready (write_data_ready),
        .out_data  (write_data)
    );

endmodule

// ==== design/simple_dma.sv ====
`timescale 1ns/1ps

module simple_dma
    import dma_pkg::*;
#(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   read_addr_valid,
    output logic                   read_addr_ready,
    input  addr_t                  read_addr,
    input  logic                   read_count_valid,
    output logic                   read_count_ready,
    input  logic [COUNT_WIDTH-1:0] read_count,
    input  logic                   write_addr_valid,
    output logic                   write_addr_ready,
    input  addr_t                  write_addr,
    input  logic                   write_count_valid,
    output logic                   write_count_ready,
    input  logic [COUNT_WIDTH-1:0] write_count,

    output logic                   read_data_valid,
    input  logic                   read_data_ready,
    output data_t                  read_data,
    input  logic                   write_data_valid,
    output logic                   write_data_ready,
    input  data_t                  write_data,

    output logic                   ar_valid,
    input  logic                   ar_ready,
    output axi_ar_t                ar,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  axi_r_t                 r,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output axi_ar_t                aw,
    output logic                   w_valid,
    input  logic                   w_ready,
    output axi_w_t                 w,
    input  logic                   b_valid,
    output logic                   b_ready,

    output logic                   r_idle,
    output logic                   w_idle
);

    rd_state_t r_state, r_state_next;
    wr_state_t w_state, w_state_next;

    addr_t                  rd_addr, wr_addr;
    logic [COUNT_WIDTH-1:0] rd_count, wr_count;   // words not yet requested.
    burst_len_t             rd_len, wr_len;
    logic [8:0]             rd_beats, wr_beats;
    burst_len_t             beats_left;           // W beats still due in this burst.

    logic ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic read_addr_fire, read_count_fire, write_addr_fire, write_count_fire;

    // bursts are capped at 256 beats, the remainder goes in the next one.
    function automatic burst_len_t next_len(input logic [COUNT_WIDTH-1:0] left);
        logic [31:0] wide;
        wide = 32'(left);
        if (wide >= max_burst) begin
            return burst_len_t'(max_burst - 1);
        end
        return burst_len_t'(wide - 32'd1);
    endfunction

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    assign read_addr_fire   = read_addr_valid && read_addr_ready;
    assign read_count_fire  = read_count_valid && read_count_ready;
    assign write_addr_fire  = write_addr_valid && write_addr_ready;
    assign write_count_fire = write_count_valid && write_count_ready;

    assign rd_len   = next_len(rd_count);
    assign wr_len   = next_len(wr_count);
    assign rd_beats = {1'b0, rd_len} + 9'd1;
    assign wr_beats = {1'b0, wr_len} + 9'd1;

    // ==============================
    // read half
    // ==============================

    always_comb begin
        case (r_state)
            R_IDLE:  r_state_next = read_count_fire && read_count != '0 ? R_DO_AR : R_IDLE;
            R_DO_AR: r_state_next = ar_fire ? R_DO_R : R_DO_AR;
            R_DO_R: begin
                if (r_fire && r.last) begin
                    r_state_next = rd_count != '0 ? R_DO_AR : R_IDLE;
                end else begin
                    r_state_next = R_DO_R;
                end
            end
            default: r_state_next = R_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_state  <= R_IDLE;
            rd_count <= '0;
        end else begin
            r_state <= r_state_next;
            if (ar_fire) begin
                rd_count <= rd_count - COUNT_WIDTH'(rd_beats);
            end else if (read_count_fire) begin
                rd_count <= read_count;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr <= rd_addr + (addr_t'(rd_beats) << word_bytes_log2);
        end else if (read_addr_fire) begin
            rd_addr <= read_addr;
        end
    end

    assign ar_valid = r_state == R_DO_AR;
    assign ar       = '{addr: rd_addr, len: rd_len};

    // read beats pass straight through to the FIFO.
    assign r_ready         = r_state == R_DO_R && read_data_ready;
    assign read_data_valid = r_state == R_DO_R && r_valid;
    assign read_data       = r.data;

    assign read_addr_ready  = r_state == R_IDLE;
    assign read_count_ready = r_state == R_IDLE;
    assign r_idle           = r_state == R_IDLE;

    // ==============================
    // write half
    // ==============================

    always_comb begin
        case (w_state)
            W_IDLE:  w_state_next = write_count_fire && write_count != '0 ? W_DO_AW : W_IDLE;
            W_DO_AW: w_state_next = aw_fire ? W_DO_W : W_DO_AW;
            W_DO_W:  w_state_next = w_fire && w.last ? W_DO_B : W_DO_W;
            W_DO_B: begin
                if (b_fire) begin
                    w_state_next = wr_count != '0 ? W_DO_AW : W_IDLE;
                end else begin
                    w_state_next = W_DO_B;
                end
            end
            default: w_state_next = W_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            w_state    <= W_IDLE;
            wr_count   <= '0;
            beats_left <= '0;
        end else begin
            w_state <= w_state_next;
            if (aw_fire) begin
                wr_count   <= wr_count - COUNT_WIDTH'(wr_beats);
                beats_left <= wr_len;
            end else begin
                if (write_count_fire) begin
                    wr_count <= write_count;
                end
                if (w_fire) begin
                    beats_left <= beats_left - 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr <= wr_addr + (addr_t'(wr_beats) << word_bytes_log2);
        end else if (write_addr_fire) begin
            wr_addr <= write_addr;
        end
    end

    assign aw_valid = w_state == W_DO_AW;
    assign aw       = '{addr: wr_addr, len: wr_len};

    assign w_valid          = w_state == W_DO_W && write_data_valid;
    assign write_data_ready = w_state == W_DO_W && w_ready;
    assign w                = '{data: write_data, last: beats_left == 8'd0};

    assign b_ready = w_state == W_DO_B;

    assign write_addr_ready  = w_state == W_IDLE;
    assign write_count_ready = w_state == W_IDLE;
    assign w_idle            = w_state == W_IDLE;

endmodule

// ==== design/copy_sequencer.sv ====
`timescale 1ns/1ps

module copy_sequencer
    import dma_pkg::*;
#(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  copy_cmd_t              cmd,

    output logic                   read_addr_valid,
    input  logic                   read_addr_ready,
    output addr_t                  read_addr,
    output logic                   read_count_valid,
    input  logic                   read_count_ready,
    output logic [COUNT_WIDTH-1:0] read_count,
    output logic                   write_addr_valid,
    input  logic                   write_addr_ready,
    output addr_t                  write_addr,
    output logic                   write_count_valid,
    input  logic                   write_count_ready,
    output logic [COUNT_WIDTH-1:0] write_count,

    input  logic                   r_idle,
    input  logic                   w_idle,
    output logic                   done
);

    seq_state_t state;
    copy_cmd_t  cmd_q;
    logic [3:0] pending;    // load channels not yet taken, write count in the top bit.
    logic [3:0] fire;
    logic       load_done;
    logic       zero_count;

    assign fire = {write_count_valid && write_count_ready,
                   write_addr_valid && write_addr_ready,
                   read_count_valid && read_count_ready,
                   read_addr_valid && read_addr_ready};
    assign load_done  = (pending & ~fire) == 4'b0000;
    assign zero_count = read_count == '0;

    assign cmd_ready         = state == IDLE;
    assign read_addr_valid   = state == LOAD && pending[0];
    assign read_count_valid  = state == LOAD && pending[1];
    assign write_addr_valid  = state == LOAD && pending[2];
    assign write_count_valid = state == LOAD && pending[3];

    assign read_addr   = cmd_q.src;
    assign read_count  = cmd_q.count[COUNT_WIDTH-1:0];
    assign write_addr  = cmd_q.dst;
    assign write_count = cmd_q.count[COUNT_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            pending <= 4'b0000;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        state   <= LOAD;
                        pending <= 4'b1111;
                    end
                end
                LOAD: begin
                    pending <= pending & ~fire;
                    if (load_done) begin
                        // the DMA stays idle on a zero load, so there is nothing to wait for.
                        state <= zero_count ? IDLE : BUSY;
                        done  <= zero_count;
                    end
                end
                BUSY: begin
                    if (r_idle && w_idle) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo
    import dma_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  in_valid,
    output logic  in_ready,
    input  data_t in_data,

    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    data_t                mem [FIFO_DEPTH];
    logic [PTR_WIDTH:0]   wr_ptr, rd_ptr;   // top bit flips on every wrap.
    logic                 full, empty;
    logic                 push, pop;

    assign empty = wr_ptr == rd_ptr;
    assign full  = wr_ptr[PTR_WIDTH] != rd_ptr[PTR_WIDTH] &&
                   wr_ptr[PTR_WIDTH-1:0] == rd_ptr[PTR_WIDTH-1:0];

    // a full buffer still takes a word when the head leaves in the same cycle.
    assign in_ready  = !full || out_ready;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[PTR_WIDTH-1:0]];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[PTR_WIDTH-1:0]] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== design/dma_pkg.sv ====
package dma_pkg;

    // ==============================
    // widths and constants
    // ==============================

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  burst_len_t;   // beats minus one, as on the bus.
    typedef logic [1:0]  resp_t;

    localparam int word_bytes_log2 = 2;  // a beat is one 32-bit word.
    localparam int max_burst = 256;

    // ==============================
    // channel payloads
    // ==============================

    // used for both AR and AW.
    typedef struct packed {
        addr_t      addr;
        burst_len_t len;
    } axi_ar_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        addr_t       src;
        addr_t       dst;
        logic [15:0] count;   // in words.
    } copy_cmd_t;

    typedef enum logic [1:0] {IDLE, LOAD, BUSY} seq_state_t;
    typedef enum logic [1:0] {R_IDLE, R_DO_AR, R_DO_R} rd_state_t;
    typedef enum logic [1:0] {W_IDLE, W_DO_AW, W_DO_W, W_DO_B} wr_state_t;

endpackage
